// ==== display_mux.sv ====
// data lamp source select
`timescale 1ns/1ps

module display_mux (
  input  logic                     clk,
  input  logic                     reset,
  input  panel_pkg::display_mode_t mode,
  input  panel_pkg::word12_t       tx_char,
  input  panel_pkg::word12_t       rx_char,
  input  panel_pkg::word12_t       sr,
  input  panel_pkg::switch_bank_t  switches,
  input  panel_pkg::word12_t       walk_word,
  output panel_pkg::word12_t       data_word
);

  import panel_pkg::*;

  word12_t switch_word;

  // sw lands on the leftmost lamp, dep on bit 3
  assign switch_word = {switches, 3'b000};

  always_ff @(posedge clk) begin
    if (reset) begin
      data_word <= '0;
    end else begin
      case (mode)
        MODE_TX:         data_word <= tx_char;  // changes every frame
        MODE_SR:         data_word <= sr;
        MODE_SWITCHES:   data_word <= switch_word;
        MODE_WALK_LEFT:  data_word <= walk_word;
        MODE_WALK_RIGHT: data_word <= walk_word;
        MODE_RX:         data_word <= rx_char;
        default:         data_word <= data_word;  // not one-hot, keep lamps
      endcase
    end
  end

endmodule

// ==== panel_assertions.sv ====
// sequencer and transmitter checks
`timescale 1ns/1ps

module panel_assertions (
  input logic                     clk,
  input logic                     reset,
  input panel_pkg::display_mode_t mode,
  input logic [4:0]               dsel_led,
  input logic                     tx
);

  // exactly one data lamp source at a time
  mode_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot(mode))
    else $error("display mode %b is not one-hot", mode);

  led_code_valid: assert property (@(posedge clk) disable iff (reset)
    dsel_led inside {5'b01100, 5'b01010, 5'b01001, 5'b10100, 5'b10010, 5'b10001})
    else $error("select lamps show an unknown code %b", dsel_led);

  // line stays idle while the transmitter is held
  tx_idle_in_reset: assert property (@(posedge clk) reset |=> tx)
    else $error("tx went low during reset");

endmodule

bind panel_top panel_assertions u_assertions (
  .clk      (clk),
  .reset    (reset),
  .mode     (mode),
  .dsel_led (dsel_led),
  .tx       (tx)
);

// ==== panel_defs.svh ====
// panel exerciser parameters
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// serial line, clocks per bit
// short value keeps simulation frames quick
`define BAUD_DIV 8

// tick period minus one, drives the walking bit
`define PPS_CNT 64

// select switch hold-off after a mode change
`define DSEL_HOLD 64

// printable characters before each CR LF
`define LINE_COLS 80

// lowest counter bit shown on the address lamps
`define ADDR_SHIFT 2

`endif

// ==== panel_pkg.sv ====
// panel exerciser types
package panel_pkg;

  // one panel word: lamp data, switch register or a character
  typedef logic [11:0] word12_t;

  // control switches, sw in the msb
  typedef struct packed {
    logic sw;
    logic addr_load;
    logic extd_addr;
    logic clear;
    logic cont;
    logic exam;
    logic halt;
    logic single_step;
    logic dep;
  } switch_bank_t;

  // one-hot data lamp source
  typedef logic [5:0] display_mode_t;

  localparam display_mode_t MODE_TX         = 6'b000001;  // last char sent
  localparam display_mode_t MODE_SR         = 6'b000010;  // switch register
  localparam display_mode_t MODE_SWITCHES   = 6'b000100;
  localparam display_mode_t MODE_WALK_LEFT  = 6'b001000;
  localparam display_mode_t MODE_WALK_RIGHT = 6'b010000;
  localparam display_mode_t MODE_RX         = 6'b100000;  // last char received

endpackage

// ==== panel_sequencer.sv ====
// display select and lamp sequencing
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_sequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     dsel_sw,
  output panel_pkg::display_mode_t mode,
  output logic [4:0]               dsel_led,
  output panel_pkg::word12_t       walk_word,
  output logic [14:0]              addr_count
);

  import panel_pkg::*;

  localparam int HOLD_W = $clog2(`DSEL_HOLD + 1);
  localparam int PPS_W  = $clog2(`PPS_CNT + 1);
  localparam int CNT_W  = `ADDR_SHIFT + 15;

  logic [HOLD_W-1:0] hold_cnt;
  logic [PPS_W-1:0]  pps_cnt;
  logic              tick;
  logic              dsel_prev;
  logic              dsel_rise;
  logic [CNT_W-1:0]  count_q;

  assign dsel_rise = dsel_sw && !dsel_prev;

  // select press rotates rx, walk right, walk left, switches, sr, tx
  always_ff @(posedge clk) begin
    if (reset) begin
      mode      <= MODE_RX;
      hold_cnt  <= '0;
      dsel_prev <= 1'b0;
    end else begin
      dsel_prev <= dsel_sw;
      if (dsel_rise && hold_cnt == '0) begin
        mode     <= {mode[0], mode[5:1]};
        hold_cnt <= HOLD_W'(`DSEL_HOLD);  // contact bounce is ignored
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dsel_led <= 5'b01100;
    end else begin
      case (mode)
        MODE_WALK_RIGHT: dsel_led <= 5'b01010;
        MODE_WALK_LEFT:  dsel_led <= 5'b01001;
        MODE_SWITCHES:   dsel_led <= 5'b10100;
        MODE_SR:         dsel_led <= 5'b10010;
        MODE_TX:         dsel_led <= 5'b10001;
        default:         dsel_led <= 5'b01100;  // rx
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pps_cnt <= PPS_W'(`PPS_CNT);
      tick    <= 1'b0;
    end else if (pps_cnt == '0) begin
      pps_cnt <= PPS_W'(`PPS_CNT);
      tick    <= 1'b1;
    end else begin
      pps_cnt <= pps_cnt - 1'b1;
      tick    <= 1'b0;
    end
  end

  // single lit bit, empty word restarts the walk
  always_ff @(posedge clk) begin
    if (reset) begin
      walk_word <= '0;
    end else if (tick && mode == MODE_WALK_LEFT) begin
      walk_word <= (walk_word == '0) ? 12'o0001 : walk_word << 1;
    end else if (tick && mode == MODE_WALK_RIGHT) begin
      walk_word <= (walk_word == '0) ? 12'o4000 : walk_word >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign addr_count = count_q[CNT_W-1:`ADDR_SHIFT];  // low bits run too fast to see

endmodule

// ==== panel_sync.sv ====
// panel input synchronizer
`timescale 1ns/1ps

module panel_sync #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t raw_n,   // active low from the panel
  output payload_t level    // active high, two cycles later
);

  payload_t meta_n;
  payload_t sync_n;

  // all ones is the released state of every switch
  always_ff @(posedge clk) begin
    if (reset) begin
      meta_n <= '1;
      sync_n <= '1;
    end else begin
      meta_n <= raw_n;
      sync_n <= meta_n;
    end
  end

  assign level = payload_t'(~sync_n);

endmodule

// ==== panel_top.sv ====
// front panel exerciser top
`timescale 1ns/1ps

module panel_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rx,
  input  panel_pkg::word12_t      sr_n,
  input  panel_pkg::switch_bank_t switches_n,
  input  logic                    dsel_sw_n,
  output logic                    tx,
  output logic [14:0]             addr_lamps_n,
  output panel_pkg::word12_t      data_lamps_n,
  output logic [4:0]              dsel_led
);

  import panel_pkg::*;

  // control switches and select button share one synchronizer
  typedef struct packed {
    switch_bank_t bank;
    logic         dsel;
  } ctrl_t;

  ctrl_t         ctrl_n;
  ctrl_t         ctrl;
  word12_t       sr;
  word12_t       tx_char;
  word12_t       rx_char;
  word12_t       walk_word;
  word12_t       data_word;
  display_mode_t mode;
  logic [14:0]   addr_count;

  assign ctrl_n = '{bank: switches_n, dsel: dsel_sw_n};

  panel_sync #(.payload_t(word12_t)) u_sr_sync (
    .clk   (clk),
    .reset (reset),
    .raw_n (sr_n),
    .level (sr)
  );

  panel_sync #(.payload_t(ctrl_t)) u_ctrl_sync (
    .clk   (clk),
    .reset (reset),
    .raw_n (ctrl_n),
    .level (ctrl)
  );

  serial_tx u_tx (
    .clk     (clk),
    .reset   (reset),
    .tx      (tx),
    .tx_char (tx_char)
  );

  serial_rx u_rx (
    .clk     (clk),
    .reset   (reset),
    .rx      (rx),
    .rx_char (rx_char)
  );

  panel_sequencer u_seq (
    .clk        (clk),
    .reset      (reset),
    .dsel_sw    (ctrl.dsel),
    .mode       (mode),
    .dsel_led   (dsel_led),
    .walk_word  (walk_word),
    .addr_count (addr_count)
  );

  display_mux u_mux (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .tx_char   (tx_char),
    .rx_char   (rx_char),
    .sr        (sr),
    .switches  (ctrl.bank),
    .walk_word (walk_word),
    .data_word (data_word)
  );

  // lamp drivers sink current, lit on low
  assign addr_lamps_n = ~addr_count;
  assign data_lamps_n = ~data_word;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the panel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_panel -f sim.f
./obj_dir/Vtb_panel | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== serial_rx.sv ====
// serial 8N1 receiver
`timescale 1ns/1ps
`include "panel_defs.svh"

module serial_rx (
  input  logic               clk,
  input  logic               reset,
  input  logic               rx,
  output panel_pkg::word12_t rx_char
);

  localparam int BAUD_W = $clog2(`BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_DIV - 1);
  localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(`BAUD_DIV / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t         state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_idx;
  logic [7:0]        data_q;
  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;

  // line comes straight from the connector
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_char  <= '0;
    end else begin
      if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
      end
      case (state)
        RX_IDLE: begin
          if (rx_prev && !rx_sync) begin  // falling edge
            state    <= RX_START;
            baud_cnt <= BAUD_HALF;
          end
        end
        RX_START: begin
          if (baud_cnt == '0) begin
            // a glitch shorter than half a bit is dropped
            state    <= rx_sync ? RX_IDLE : RX_DATA;
            baud_cnt <= BAUD_LAST;
            bit_idx  <= '0;
          end
        end
        RX_DATA: begin
          if (baud_cnt == '0) begin
            baud_cnt <= BAUD_LAST;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          if (baud_cnt == '0) begin
            state <= RX_IDLE;
            if (rx_sync) begin
              rx_char <= {4'b0000, data_q};  // framing error keeps old char
            end
          end
        end
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && baud_cnt == '0) begin
      data_q <= {rx_sync, data_q[7:1]};
    end
  end

endmodule

// ==== serial_tx.sv ====
// serial test pattern transmitter
`timescale 1ns/1ps
`include "panel_defs.svh"

module serial_tx (
  input  logic               clk,
  input  logic               reset,
  output logic               tx,
  output panel_pkg::word12_t tx_char
);

  localparam int BAUD_W = $clog2(`BAUD_DIV);
  localparam int COL_W  = $clog2(`LINE_COLS);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_DIV - 1);
  localparam logic [COL_W-1:0]  COL_LAST  = COL_W'(`LINE_COLS - 1);
  localparam logic [7:0] CHAR_FIRST = 8'h20;  // space
  localparam logic [7:0] CHAR_LAST  = 8'h7e;  // tilde
  localparam logic [7:0] CHAR_CR    = 8'h0d;
  localparam logic [7:0] CHAR_LF    = 8'h0a;

  typedef enum logic [1:0] {
    GEN_PRINT,
    GEN_CR,
    GEN_LF
  } gen_state_t;

  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;     // bits left after the start bit
  logic [8:0]        shift_q;     // data lsb first, stop bit on top
  logic [COL_W-1:0]  col_cnt;
  logic [7:0]        print_char;  // next printable character
  gen_state_t        gen_state;
  logic [7:0]        next_char;
  logic              frame_start;

  always_comb begin
    case (gen_state)
      GEN_CR:  next_char = CHAR_CR;
      GEN_LF:  next_char = CHAR_LF;
      default: next_char = print_char;
    endcase
  end

  // previous stop bit has run its full length
  assign frame_start = (baud_cnt == '0) && (bit_cnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      tx       <= 1'b1;  // line idles high
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_char  <= '0;
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end else begin
      baud_cnt <= BAUD_LAST;
      if (frame_start) begin
        tx      <= 1'b0;  // start bit
        bit_cnt <= 4'd9;
        tx_char <= {4'b0000, next_char};
      end else begin
        tx      <= shift_q[0];
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_start) begin
      shift_q <= {1'b1, next_char};
    end else if (baud_cnt == '0) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  // character generator, steps once per frame
  always_ff @(posedge clk) begin
    if (reset) begin
      gen_state  <= GEN_PRINT;
      print_char <= CHAR_FIRST;
      col_cnt    <= '0;
    end else if (frame_start) begin
      case (gen_state)
        GEN_PRINT: begin
          print_char <= (print_char == CHAR_LAST) ? CHAR_FIRST : print_char + 8'd1;
          if (col_cnt == COL_LAST) begin
            col_cnt   <= '0;
            gen_state <= GEN_CR;  // line full
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
        GEN_CR:  gen_state <= GEN_LF;
        default: gen_state <= GEN_PRINT;
      endcase
    end
  end

endmodule

// ==== sim.f ====
+incdir+.
panel_pkg.sv
panel_sync.sv
serial_tx.sv
serial_rx.sv
panel_sequencer.sv
display_mux.sv
panel_top.sv
panel_assertions.sv
tb_panel.sv

// ==== tb_panel.sv ====
// front panel exerciser testbench
`timescale 1ns/1ps
`include "panel_defs.svh"

module tb_panel;

  localparam int TIMEOUT_CYCLES = 40000;  // all tests take about 10000 cycles
  // select lamp codes after each press, starting from rx
  localparam logic [4:0] LED_CODES [6] = '{5'b01010, 5'b01001, 5'b10100,
                                           5'b10010, 5'b10001, 5'b01100};

  logic        clk;
  logic        reset;
  logic        rx;
  logic [11:0] sr_n;
  logic [8:0]  switches_n;
  logic        dsel_sw_n;
  logic        tx;
  logic [14:0] addr_lamps_n;
  logic [11:0] data_lamps_n;
  logic [4:0]  dsel_led;

  int          cycle_count = 0;
  int          test_errors = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] rng;
  logic [7:0]  last_rx = 8'h00;

  panel_top DUT (
    .clk          (clk),
    .reset        (reset),
    .rx           (rx),
    .sr_n         (sr_n),
    .switches_n   (switches_n),
    .dsel_sw_n    (dsel_sw_n),
    .tx           (tx),
    .addr_lamps_n (addr_lamps_n),
    .data_lamps_n (data_lamps_n),
    .dsel_led     (dsel_led)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // n-th character on the line: printables wrap, CR LF after each full line
  function automatic logic [7:0] pattern_char(input int n);
    int col;
    int printed;
    col = n % (`LINE_COLS + 2);
    printed = (n / (`LINE_COLS + 2)) * `LINE_COLS + col;
    if (col == `LINE_COLS) return 8'h0d;
    if (col == `LINE_COLS + 1) return 8'h0a;
    return 8'(32 + printed % 95);
  endfunction

  function automatic logic [11:0] walk_next(input logic [11:0] w, input logic left);
    if (w == 12'o0000) return left ? 12'o0001 : 12'o4000;
    return left ? (w << 1) : (w >> 1);
  endfunction

  function automatic logic [11:0] lamp_word();
    return ~data_lamps_n;  // lit lamps read as ones
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check_equal(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("** Error %s: expected %0h, actual %0h", test, expected, actual);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("pass  %s", name);
    end else begin
      tests_failed++;
      $display("fail  %s with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic press_select();
    dsel_sw_n = 1'b0;
    wait_cycles(4);
    dsel_sw_n = 1'b1;
    wait_cycles(`DSEL_HOLD + 8);  // hold-off runs out, lamps settled long before
  endtask

  task automatic send_rx_frame(input logic [7:0] ch);
    rx = 1'b0;
    wait_cycles(`BAUD_DIV);
    for (int i = 0; i < 8; i++) begin
      rx = ch[i];
      wait_cycles(`BAUD_DIV);
    end
    rx = 1'b1;
    wait_cycles(3 * `BAUD_DIV);  // stop bit plus idle
  endtask

  // returns at the middle of the stop bit
  task automatic decode_tx_frame(output logic [7:0] ch, output logic framed);
    ch = 8'h00;
    while (tx !== 1'b0) begin
      wait_cycles(1);
    end
    wait_cycles(`BAUD_DIV / 2);
    framed = (tx === 1'b0);
    for (int i = 0; i < 8; i++) begin
      wait_cycles(`BAUD_DIV);
      ch[i] = tx;
    end
    wait_cycles(`BAUD_DIV);
    framed = framed && (tx === 1'b1);
  endtask

  task automatic wait_lamp_change(input logic [11:0] prev, output logic [11:0] now);
    int waited;
    waited = 0;
    now = lamp_word();
    while (now == prev && waited < 2 * (`PPS_CNT + 1)) begin
      wait_cycles(1);
      waited++;
      now = lamp_word();
    end
    assert (now != prev) else begin
      $display("walking_bit: data lamps did not change within %0d cycles", waited);
      test_errors++;
    end
  endtask

  task automatic reset_state();
    check_equal("reset_state", 1, tx);
    check_equal("reset_state", 5'b01100, dsel_led);
    check_equal("reset_state", 12'hfff, data_lamps_n);
    finish_test("reset_state");
  endtask

  task automatic transmit_pattern();
    logic [7:0] ch;
    logic       framed;
    fork
      begin
        for (int n = 0; n < `LINE_COLS + 5; n++) begin
          decode_tx_frame(ch, framed);
          assert (framed) else begin
            $display("transmit_pattern: frame %0d has a bad start or stop bit", n);
            test_errors++;
          end
          check_equal("transmit_pattern", pattern_char(n), ch);
          if (n >= `LINE_COLS + 2) begin
            check_equal("transmit_pattern", ch, lamp_word());  // tx mode by now
          end
        end
      end
      begin
        repeat (5) press_select();  // rx round to tx
      end
    join
    check_equal("transmit_pattern", 5'b10001, dsel_led);
    finish_test("transmit_pattern");
  endtask

  task automatic receive_char();
    logic [7:0] ch;
    press_select();  // back to rx
    check_equal("receive_char", 5'b01100, dsel_led);
    repeat (3) begin
      rng = xorshift32(rng);
      ch = rng[7:0];
      send_rx_frame(ch);
      check_equal("receive_char", ch, lamp_word());
      last_rx = ch;
    end
    finish_test("receive_char");
  endtask

  task automatic mode_rotation();
    logic [11:0] sr_value;
    logic [8:0]  sw_value;
    rng = xorshift32(rng);
    sr_value = rng[11:0];
    sw_value = rng[20:12];
    sr_n = ~sr_value;
    switches_n = ~sw_value;
    for (int i = 0; i < 6; i++) begin
      press_select();
      check_equal("mode_rotation", LED_CODES[i], dsel_led);
      case (i)
        2: check_equal("mode_rotation", {sw_value, 3'b000}, lamp_word());
        3: check_equal("mode_rotation", sr_value, lamp_word());
        5: check_equal("mode_rotation", last_rx, lamp_word());
        default: ;
      endcase
    end
    finish_test("mode_rotation");
  endtask

  task automatic walking_bit();
    logic [11:0] prev;
    logic [11:0] now;
    for (int dir = 0; dir < 2; dir++) begin
      press_select();  // walk right first, then walk left
      prev = lamp_word();
      for (int step = 0; step < 14; step++) begin
        wait_lamp_change(prev, now);
        check_equal("walking_bit", walk_next(prev, dir == 1), now);
        prev = now;
      end
    end
    finish_test("walking_bit");
  endtask

  task automatic address_sweep();
    logic [14:0] prev;
    logic [14:0] now;
    prev = ~addr_lamps_n;
    repeat (20) begin
      wait_cycles(1 << `ADDR_SHIFT);
      now = ~addr_lamps_n;
      check_equal("address_sweep", 15'(prev + 15'd1), now);
      prev = now;
    end
    finish_test("address_sweep");
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    rx = 1'b1;
    sr_n = '1;
    switches_n = '1;
    dsel_sw_n = 1'b1;
    rng = 32'd86936;
    wait_cycles(16);
    reset = 1'b0;
    reset_state();
    transmit_pattern();  // first frame starts right after reset
    receive_char();
    mode_rotation();
    walking_bit();
    address_sweep();
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
